/* Makefile */
# Verilator build and run for the layer controller testbench

VERILATOR ?= verilator
TOP       ?= tb_layer_ctrl
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f $(FILELIST)

# The simulator exits non-zero on any failing check
run: build
	./$(OBJ_DIR)/$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* rtl/int_action_table.sv */
// Fixed test actions A1 to D1 in entries 0 to 12; any other index returns an all-zero action
`timescale 1ns/1ns
`include "lc_params.svh"

module int_action_table
	import lc_pkg::*;
(
	input	int_idx_t	int_sel,
	output	lc_action_t	action
);

	localparam mbus_addr_t RF_REPLY = {4'd4, `LC_CMD_RF_WRITE};	// Layer 4, RF write
	localparam mbus_addr_t MEM_REPLY = {4'd4, `LC_CMD_MEM_WRITE};	// Layer 4, SRAM write

	// RF read: start, length - 1, reply address, reply location in word 0
	function automatic lc_action_t rf_rd_action(
		input rf_addr_t		from,
		input logic [7:0]	len_m1,
		input mbus_addr_t	reply,
		input logic [7:0]	loc,
		input cmd_len_t		len
	);
		lc_action_t a;
		a = '0;
		a.func_id = `LC_CMD_RF_READ;
		a.cmd_len = len;
		a.payload[0] = {from, len_m1, reply, loc};
		return a;
	endfunction

	// Memory read uses all three words, 4 bits reserved in word 0
	function automatic lc_action_t mem_rd_action(
		input mbus_addr_t	reply,
		input logic [19:0]	len_m1,
		input mem_addr_t	start,
		input mem_addr_t	loc
	);
		lc_action_t a;
		a.func_id = `LC_CMD_MEM_READ;
		a.cmd_len = 2'd3;
		a.payload[0] = {reply, 4'b0, len_m1};
		a.payload[1] = {start, 2'b0};
		a.payload[2] = {loc, 2'b0};	// Sent back unchanged as head word
		return a;
	endfunction

	always_comb
	begin
		action = '0;
		case (int_sel)
			4'd0:	action = rf_rd_action(8'd0, 8'd0, RF_REPLY, 8'd0, 2'd1);	// A1
			4'd1:	action = rf_rd_action(8'd1, 8'd0, RF_REPLY, 8'd1, 2'd2);	// A2
			4'd2:	action = rf_rd_action(8'd2, 8'd4, RF_REPLY, 8'd2, 2'd1);	// A3
			4'd3:	action = rf_rd_action(8'd126, 8'd4, RF_REPLY, 8'd7, 2'd1);	// A4, runs off RF end
			4'd4:						// B1, one write
			begin
				action.func_id = `LC_CMD_RF_WRITE;
				action.cmd_len = 2'd1;
				action.payload[0] = {8'd0, 24'habcdef};
			end
			4'd5:						// B2
			begin
				action.func_id = `LC_CMD_RF_WRITE;
				action.cmd_len = 2'd2;
				action.payload[0] = {8'd1, 24'h123456};
				action.payload[1] = {8'd3, 24'h987654};
			end
			4'd6:						// B3
			begin
				action.func_id = `LC_CMD_RF_WRITE;
				action.cmd_len = 2'd3;
				action.payload[0] = {8'd2, 24'h123321};
				action.payload[1] = {8'd4, 24'habccba};
				action.payload[2] = {8'd6, 24'h090785};
			end
			4'd7:						// B4, last two must be dropped
			begin
				action.func_id = `LC_CMD_RF_WRITE;
				action.cmd_len = 2'd3;
				action.payload[0] = {8'd5, 24'h052986};
				action.payload[1] = {8'd127, 24'h031783};	// Read-only
				action.payload[2] = {8'd128, 24'h101614};	// Past RF end
			end
			4'd8:	action = mem_rd_action(MEM_REPLY, 20'd0, 30'd0, 30'd1);		// C1
			4'd9:	action = mem_rd_action(MEM_REPLY, 20'd4, 30'd1, 30'd2);		// C2
			4'd10:	action = mem_rd_action(MEM_REPLY, 20'd0, 30'd65538, 30'd3);	// C3, wraps
			4'd11:	action = mem_rd_action(MEM_REPLY, 20'd9, 30'd65533, 30'd3);	// C4, crosses end
			4'd12:	action = '0;				// D1, wake only
			default: action = '0;
		endcase
	end

endmodule

/* rtl/layer_ctrl.sv */
// Interrupt-action layer controller; memory loads only through the preload port, tx has no ready
`timescale 1ns/1ns
`include "lc_params.svh"

module layer_ctrl
	import lc_pkg::*;
(
	input	logic				clk,
	input	logic				rst,
	input	logic [`LC_INT_DEPTH-1:0]	int_req,	// One-cycle pulse per line
	input	logic				mem_wr_en,
	input	mem_addr_t			mem_wr_addr,
	input	lc_word_t			mem_wr_data,
	output	logic				wakeup,
	output	logic				busy,
	output	logic				tx_valid,
	output	lc_result_t			tx_word,
	output	logic				done
);

	int_idx_t	int_sel;
	lc_action_t	action;
	lc_op_t		op;
	logic		op_valid;
	logic		op_done;
	logic		rf_we;
	rf_addr_t	rf_waddr;
	rf_data_t	rf_wdata;
	rf_addr_t	rf_raddr;
	rf_data_t	rf_rdata;
	lc_result_t	res;
	logic		res_valid;

	int_action_table table_i (
		.int_sel	(int_sel),
		.action		(action)
	);

	lc_cmd_decode decode_i (
		.clk		(clk),
		.rst		(rst),
		.int_req	(int_req),
		.action		(action),
		.op_done	(op_done),
		.int_sel	(int_sel),
		.op		(op),
		.op_valid	(op_valid),
		.wakeup		(wakeup),
		.busy		(busy),
		.done		(done)
	);

	lc_cmd_execute execute_i (
		.clk		(clk),
		.rst		(rst),
		.op		(op),
		.op_valid	(op_valid),
		.mem_wr_en	(mem_wr_en),
		.mem_wr_addr	(mem_wr_addr),
		.mem_wr_data	(mem_wr_data),
		.rf_rdata	(rf_rdata),
		.rf_we		(rf_we),
		.rf_waddr	(rf_waddr),
		.rf_wdata	(rf_wdata),
		.rf_raddr	(rf_raddr),
		.res		(res),
		.res_valid	(res_valid),
		.op_done	(op_done)
	);

	lc_reg_file rf_i (
		.clk		(clk),
		.rst		(rst),
		.we		(rf_we),
		.waddr		(rf_waddr),
		.wdata		(rf_wdata),
		.raddr		(rf_raddr),
		.rdata		(rf_rdata)
	);

	lc_reply_gen reply_i (
		.clk		(clk),
		.rst		(rst),
		.res		(res),
		.res_valid	(res_valid),
		.tx_word	(tx_word),
		.tx_valid	(tx_valid)
	);

endmodule

/* rtl/lc_cmd_decode.sv */
// Services one interrupt at a time, lowest line first; one op in flight, no back-pressure
`timescale 1ns/1ns
`include "lc_params.svh"

module lc_cmd_decode
	import lc_pkg::*;
(
	input	logic				clk,
	input	logic				rst,
	input	logic [`LC_INT_DEPTH-1:0]	int_req,
	input	lc_action_t			action,
	input	logic				op_done,
	output	int_idx_t			int_sel,
	output	lc_op_t				op,
	output	logic				op_valid,
	output	logic				wakeup,
	output	logic				busy,
	output	logic				done
);

	decode_state_t			state;
	logic [`LC_INT_DEPTH-1:0]	pend;		// Latched requests
	logic [`LC_INT_DEPTH-1:0]	pick_mask;	// One-hot of chosen line
	int_idx_t			pick_idx;
	cmd_len_t			step;		// Ops already finished
	cmd_len_t			n_ops;		// Ops for current entry
	op_kind_t			kind;

	// Lowest pending line wins
	always_comb
	begin
		pick_idx = '0;
		pick_mask = '0;
		for (int i = `LC_INT_DEPTH - 1; i >= 0; i--)
			if (pend[i])
				pick_idx = int_idx_t'(i);
		pick_mask[pick_idx] = |pend;
	end

	// RF write gives one op per word, reads give a single op
	always_comb
	begin
		case (action.func_id)
			`LC_CMD_RF_WRITE:
			begin
				kind = OP_RF_WRITE;
				n_ops = action.cmd_len;
			end
			`LC_CMD_RF_READ:
			begin
				kind = OP_RF_READ;
				n_ops = (action.cmd_len != 2'd0) ? 2'd1 : 2'd0;
			end
			`LC_CMD_MEM_READ:
			begin
				kind = OP_MEM_READ;
				n_ops = (action.cmd_len != 2'd0) ? 2'd1 : 2'd0;
			end
			default:
			begin
				kind = OP_NONE;		// Unknown ID acts as wake only
				n_ops = 2'd0;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= DEC_IDLE;
			pend <= '0;
			int_sel <= '0;
			step <= '0;
			op_valid <= 1'b0;
			wakeup <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			op_valid <= 1'b0;
			wakeup <= 1'b0;
			done <= 1'b0;
			// New pulses always land, even while busy
			pend <= (pend | int_req) & ~((state == DEC_IDLE) ? pick_mask : '0);
			case (state)
				DEC_IDLE:
					if (|pend)
					begin
						int_sel <= pick_idx;
						step <= '0;
						wakeup <= 1'b1;
						busy <= 1'b1;
						state <= DEC_ISSUE;
					end
				DEC_ISSUE:
					if (step == n_ops)
					begin
						done <= 1'b1;	// Nothing (left) to run
						busy <= 1'b0;
						state <= DEC_IDLE;
					end
					else
					begin
						op.kind <= kind;
						op.word0 <= (kind == OP_RF_WRITE) ? action.payload[step]
							: action.payload[0];
						op.word1 <= action.payload[1];
						op.word2 <= action.payload[2];
						op_valid <= 1'b1;
						state <= DEC_WAIT;
					end
				DEC_WAIT:
					if (op_done)
					begin
						step <= step + 2'd1;
						state <= DEC_ISSUE;	// ISSUE ends the entry
					end
				default: state <= DEC_IDLE;
			endcase
		end
	end

endmodule

/* rtl/lc_cmd_execute.sv */
// Memory depth must be a power of two; RF reads take two cycles per word, memory one
`timescale 1ns/1ns
`include "lc_params.svh"

module lc_cmd_execute
	import lc_pkg::*;
(
	input	logic		clk,
	input	logic		rst,
	input	lc_op_t		op,
	input	logic		op_valid,
	input	logic		mem_wr_en,
	input	mem_addr_t	mem_wr_addr,
	input	lc_word_t	mem_wr_data,
	input	rf_data_t	rf_rdata,
	output	logic		rf_we,
	output	rf_addr_t	rf_waddr,
	output	rf_data_t	rf_wdata,
	output	rf_addr_t	rf_raddr,
	output	lc_result_t	res,
	output	logic		res_valid,
	output	logic		op_done
);

	localparam int MEM_AW = $clog2(`LC_MEM_DEPTH);

	exec_state_t	state;
	logic		rd_phase;	// High when rf_rdata matches rf_ptr
	rf_addr_t	rf_ptr;
	logic [7:0]	rf_rem;		// RF words left after current
	logic [7:0]	rf_loc;		// Reply location of current word
	mbus_addr_t	reply_dest;
	mem_addr_t	mem_ptr;	// Wraps through the low bits
	logic [19:0]	mem_rem;	// Data words left after current
	lc_word_t	head_word;
	lc_word_t	mem_q;
	lc_word_t	mem [0:`LC_MEM_DEPTH-1];
	logic		rf_last;

	assign rf_raddr = rf_ptr;
	// Stop at the requested count or at the top RF entry
	assign rf_last = (rf_rem == 8'd0) || (rf_ptr == rf_addr_t'(`LC_RF_DEPTH - 1));

	// Preload port and synchronous read port
	always_ff @(posedge clk)
	begin
		if (mem_wr_en)
			mem[mem_wr_addr[MEM_AW-1:0]] <= mem_wr_data;
		mem_q <= mem[mem_ptr[MEM_AW-1:0]];
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= EX_IDLE;
			rd_phase <= 1'b0;
			rf_we <= 1'b0;
			res_valid <= 1'b0;
			op_done <= 1'b0;
			rf_ptr <= '0;
			mem_ptr <= '0;
		end
		else
		begin
			rf_we <= 1'b0;
			res_valid <= 1'b0;
			op_done <= 1'b0;
			case (state)
				EX_IDLE:
					if (op_valid)
					begin
						case (op.kind)
							OP_RF_WRITE:
							begin
								rf_we <= 1'b1;		// Range rules live in RF
								rf_waddr <= op.word0[31:24];
								rf_wdata <= op.word0[23:0];
								op_done <= 1'b1;
							end
							OP_RF_READ:
							begin
								rf_ptr <= op.word0[31:24];
								rf_rem <= op.word0[23:16];
								reply_dest <= op.word0[15:8];
								rf_loc <= op.word0[7:0];
								rd_phase <= 1'b0;
								if (32'(op.word0[31:24]) < `LC_RF_DEPTH)
									state <= EX_RF_READ;
								else
									op_done <= 1'b1;	// Start past end, no reply
							end
							OP_MEM_READ:
							begin
								reply_dest <= op.word0[31:24];
								mem_rem <= op.word0[19:0];
								mem_ptr <= op.word1[31:2];
								head_word <= op.word2;
								state <= EX_MEM_HEAD;
							end
							default: op_done <= 1'b1;
						endcase
					end
				EX_RF_READ:
				begin
					rd_phase <= ~rd_phase;
					if (rd_phase)
					begin
						res_valid <= 1'b1;
						res <= '{data: {rf_loc, rf_rdata}, dest: reply_dest, last: rf_last};
						rf_ptr <= rf_ptr + 8'd1;
						rf_rem <= rf_rem - 8'd1;
						rf_loc <= rf_loc + 8'd1;
						if (rf_last)
						begin
							op_done <= 1'b1;
							state <= EX_IDLE;
						end
					end
				end
				EX_MEM_HEAD:
				begin
					res_valid <= 1'b1;
					res <= '{data: head_word, dest: reply_dest, last: 1'b0};
					mem_ptr <= mem_ptr + 30'd1;	// mem_q now holds first word
					state <= EX_MEM_DATA;
				end
				EX_MEM_DATA:
				begin
					res_valid <= 1'b1;
					res <= '{data: mem_q, dest: reply_dest, last: (mem_rem == 20'd0)};
					mem_ptr <= mem_ptr + 30'd1;
					mem_rem <= mem_rem - 20'd1;
					if (mem_rem == 20'd0)
					begin
						op_done <= 1'b1;
						state <= EX_IDLE;
					end
				end
				default: state <= EX_IDLE;
			endcase
		end
	end

endmodule

/* rtl/lc_params.svh */
// Defines only; LC_MEM_DEPTH and LC_RF_DEPTH must be powers of two, RF depth at most 256
`ifndef LC_PARAMS_SVH
`define LC_PARAMS_SVH

// Sizes of the interrupt table, register file and word memory
`define LC_INT_DEPTH		13		// Interrupt lines, one table entry each
`define LC_RF_DEPTH		128		// RF entries, 1 to 256
`define LC_RF_RO_ADDR		127		// Read-only RF address
`define LC_MEM_DEPTH		65536		// Memory words, 1 to 2^30

// Field widths
`define LC_DATA_WIDTH		32		// Bus word
`define LC_FUNC_WIDTH		4		// Function ID

// Function IDs seen on the bus
`define LC_CMD_RF_WRITE		4'd2
`define LC_CMD_RF_READ		4'd3
`define LC_CMD_MEM_WRITE	4'd4		// Only used as a reply target
`define LC_CMD_MEM_READ		4'd5

`endif

/* rtl/lc_pkg.sv */
// Types shared by the layer controller; widths come from lc_params.svh
`include "lc_params.svh"

package lc_pkg;

	// Plain vectors with a meaning
	typedef logic [`LC_DATA_WIDTH-1:0]	lc_word_t;	// One bus word
	typedef logic [`LC_FUNC_WIDTH-1:0]	lc_func_t;	// Function ID
	typedef logic [7:0]			rf_addr_t;	// RF address
	typedef logic [23:0]			rf_data_t;	// RF value
	typedef logic [29:0]			mem_addr_t;	// Word address
	typedef logic [7:0]			mbus_addr_t;	// Short addr in 7:4, func ID in 3:0
	typedef logic [3:0]			int_idx_t;	// Interrupt number
	typedef logic [1:0]			cmd_len_t;	// Payload words in use

	// Operation handed from decode to execute
	typedef enum logic [1:0] {
		OP_NONE,
		OP_RF_WRITE,
		OP_RF_READ,
		OP_MEM_READ
	} op_kind_t;

	typedef enum logic [1:0] {
		DEC_IDLE,		// Waiting for a pending interrupt
		DEC_ISSUE,		// Table entry valid, send next op
		DEC_WAIT		// Op in flight
	} decode_state_t;

	typedef enum logic [1:0] {
		EX_IDLE,
		EX_RF_READ,		// Two cycles per RF word
		EX_MEM_HEAD,		// Head word out, memory read primed
		EX_MEM_DATA		// One data word per cycle
	} exec_state_t;

	// One interrupt action; payload[k] is word k of the command
	typedef struct packed {
		lc_func_t		func_id;
		lc_word_t [2:0]		payload;
		cmd_len_t		cmd_len;
	} lc_action_t;

	typedef struct packed {
		op_kind_t		kind;
		lc_word_t		word0;
		lc_word_t		word1;
		lc_word_t		word2;
	} lc_op_t;

	// Reply word with its target and end-of-message flag
	typedef struct packed {
		lc_word_t		data;
		mbus_addr_t		dest;
		logic			last;
	} lc_result_t;

endpackage

/* rtl/lc_reg_file.sv */
// RF depth must be a power of two up to 256; writes to the read-only or missing entries are dropped
`timescale 1ns/1ns
`include "lc_params.svh"

module lc_reg_file
	import lc_pkg::*;
(
	input	logic		clk,
	input	logic		rst,
	input	logic		we,
	input	rf_addr_t	waddr,
	input	rf_data_t	wdata,
	input	rf_addr_t	raddr,
	output	rf_data_t	rdata
);

	localparam int RF_AW = $clog2(`LC_RF_DEPTH);

	rf_data_t	rf [0:`LC_RF_DEPTH-1];
	logic		wr_ok;

	// Writable only inside the array and off the read-only slot
	assign wr_ok = (32'(waddr) < `LC_RF_DEPTH) && (waddr != rf_addr_t'(`LC_RF_RO_ADDR));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `LC_RF_DEPTH; i++)
				rf[i] <= '0;		// Whole RF starts at zero
			rdata <= '0;
		end
		else
		begin
			if (we && wr_ok)
				rf[waddr[RF_AW-1:0]] <= wdata;
			if (32'(raddr) < `LC_RF_DEPTH)
				rdata <= rf[raddr[RF_AW-1:0]];
			else
				rdata <= '0;		// Missing address reads as zero
		end
	end

endmodule

/* rtl/lc_reply_gen.sv */
// Registers execute results onto the transmit strobe one cycle later; execute holds dest per message
`timescale 1ns/1ns

module lc_reply_gen
	import lc_pkg::*;
(
	input	logic		clk,
	input	logic		rst,
	input	lc_result_t	res,
	input	logic		res_valid,
	output	lc_result_t	tx_word,
	output	logic		tx_valid
);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			tx_valid <= 1'b0;
		end
		else
		begin
			tx_valid <= res_valid;
			if (res_valid)
				tx_word <= res;		// Data, destination and last as one word
		end
	end

endmodule

/* tests/layer_ctrl_tests.txt */
# M word_addr data | I line name | D line line name (both lines in one cycle)
# E dest data last, expected tx words of the interrupt above; addr, data and dest in hex
M 00000000 c0de0000
M 00000001 11111111
M 00000002 22220002
M 00000003 33330003
M 00000004 44440004
M 00000005 55550005
M 00000006 66660006
M 0000fffd fffd1234
M 0000fffe fffe5678
M 0000ffff ffff9abc
I 4 b1_write
I 5 b2_write
I 6 b3_write
I 7 b4_write
I 0 a1_read
E 42 00abcdef 1
I 1 a2_read
E 42 01123456 1
I 2 a3_read
E 42 02123321 0
E 42 03987654 0
E 42 04abccba 0
E 42 05052986 0
E 42 06090785 1
# Entry 127 stayed zero, the read stops there
I 3 a4_read
E 42 07000000 0
E 42 08000000 1
I 8 c1_mem_read
E 44 00000004 0
E 44 c0de0000 1
I 9 c2_mem_read
E 44 00000008 0
E 44 11111111 0
E 44 22220002 0
E 44 33330003 0
E 44 44440004 0
E 44 55550005 1
I 10 c3_mem_wrap
E 44 0000000c 0
E 44 22220002 1
I 11 c4_mem_cross
E 44 0000000c 0
E 44 fffd1234 0
E 44 fffe5678 0
E 44 ffff9abc 0
E 44 c0de0000 0
E 44 11111111 0
E 44 22220002 0
E 44 33330003 0
E 44 44440004 0
E 44 55550005 0
E 44 66660006 1
I 12 d1_wake
# Line 0 is served before line 8, and the write to 128 left entry 0 alone
D 0 8 a1_then_c1
E 42 00abcdef 1
E 44 00000004 0
E 44 c0de0000 1

/* tests/tb_layer_ctrl.sv */
// Runs from the project root and reads tests/layer_ctrl_tests.txt; stops with $fatal at the first error
`timescale 1ns/1ns
`include "lc_params.svh"

module tb_layer_ctrl
	import lc_pkg::*;
();

	localparam int TIMEOUT = 200;		// Cycles allowed per wait loop
	localparam int NAME_W = 8 * 32;		// Test names up to 32 chars

	logic				clk;
	logic				rst;
	logic [`LC_INT_DEPTH-1:0]	int_req;
	logic				mem_wr_en;
	mem_addr_t			mem_wr_addr;
	lc_word_t			mem_wr_data;
	logic				wakeup;
	logic				busy;
	logic				tx_valid;
	lc_result_t			tx_word;
	logic				done;

	lc_result_t			exp_q[$];	// Words still owed by the DUT
	logic [NAME_W-1:0]		test_name;

	layer_ctrl dut_i (
		.clk		(clk),
		.rst		(rst),
		.int_req	(int_req),
		.mem_wr_en	(mem_wr_en),
		.mem_wr_addr	(mem_wr_addr),
		.mem_wr_data	(mem_wr_data),
		.wakeup		(wakeup),
		.busy		(busy),
		.tx_valid	(tx_valid),
		.tx_word	(tx_word),
		.done		(done)
	);

	always #50 clk = ~clk;		// 100 ns period

	task automatic abort_run(input string msg);
		$display("%0s", msg);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_result(input lc_result_t expected, input lc_result_t actual);
		if (actual !== expected)
			abort_run($sformatf("** Error: %0s tx word expected %h/%h/%b, actual %h/%h/%b",
				test_name, expected.dest, expected.data, expected.last,
				actual.dest, actual.data, actual.last));
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("** Error: %0s %0s expected %b, actual %b",
				test_name, what, expected, actual));
	endtask

	// One preload write, then the port goes quiet
	task automatic preload_word(input mem_addr_t addr, input lc_word_t data);
		@(posedge clk);
		mem_wr_en <= 1'b1;
		mem_wr_addr <= addr;
		mem_wr_data <= data;
		@(posedge clk);
		mem_wr_en <= 1'b0;
	endtask

	// Pulse the lines together and follow the DUT until every one is done
	task automatic run_interrupts(input logic [`LC_INT_DEPTH-1:0] lines, input int n_lines);
		int cycles;
		int wakes;
		int dones;
		lc_result_t w;
		cycles = 0;
		wakes = 0;
		dones = 0;
		@(posedge clk);
		int_req <= lines;
		@(posedge clk);
		int_req <= '0;				// One-cycle pulse
		while (dones < n_lines)
		begin
			@(negedge clk);			// Outputs settled here
			cycles++;
			if (cycles > TIMEOUT)
				abort_run($sformatf("Timeout in test %0s waiting for done", test_name));
			if (wakeup)
			begin
				wakes++;
				check_flag("busy at wakeup", 1'b1, busy);
			end
			if (tx_valid)
			begin
				if (exp_q.size() == 0)
					abort_run($sformatf("Test %0s sent a tx word that was not expected",
						test_name));
				w = exp_q.pop_front();
				check_result(w, tx_word);
			end
			if (done)
			begin
				dones++;
				check_flag("busy at done", 1'b0, busy);
			end
		end
		if (wakes != n_lines)
			abort_run($sformatf("Test %0s saw %0d wakeup pulses instead of %0d",
				test_name, wakes, n_lines));
		if (exp_q.size() != 0)
			abort_run($sformatf("Test %0s finished with %0d tx words missing",
				test_name, exp_q.size()));
	endtask

	initial
	begin
		int				fd;
		int				rc;
		int				n_lines;
		logic [63:0]			kind;
		logic [8*256-1:0]		line;
		mem_addr_t			addr;
		lc_word_t			data;
		mbus_addr_t			dest;
		logic				last;
		int_idx_t			idx;
		int_idx_t			idx2;
		logic [`LC_INT_DEPTH-1:0]	lines;
		logic				have_test;
		logic				eof_seen;
		lc_result_t			w;
		clk = 1'b0;
		rst = 1'b1;
		int_req = '0;
		mem_wr_en = 1'b0;
		mem_wr_addr = '0;
		mem_wr_data = '0;
		test_name = "reset";
		lines = '0;
		n_lines = 0;
		have_test = 1'b0;
		eof_seen = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_flag("wakeup", 1'b0, wakeup);		// All quiet after reset
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);
		check_flag("tx_valid", 1'b0, tx_valid);
		fd = $fopen("tests/layer_ctrl_tests.txt", "r");
		if (fd == 0)
			abort_run("Could not open tests/layer_ctrl_tests.txt");
		while (!eof_seen)
		begin
			if ($fscanf(fd, "%s", kind) != 1)
				eof_seen = 1'b1;
			else if (kind == "#")
				rc = $fgets(line, fd);			// Comment line
			else if (kind == "M")
			begin
				rc = $fscanf(fd, "%h %h", addr, data);
				if (rc != 2)
					abort_run("Bad memory preload record in the data file");
				preload_word(addr, data);
			end
			else if (kind == "E")
			begin
				rc = $fscanf(fd, "%h %h %d", dest, data, last);
				if (rc != 3)
					abort_run("Bad expected-word record in the data file");
				w.data = data;
				w.dest = dest;
				w.last = last;
				exp_q.push_back(w);
			end
			else if (kind == "I" || kind == "D")
			begin
				if (have_test)
					run_interrupts(lines, n_lines);	// Previous test has all its words
				lines = '0;
				if (kind == "I")
				begin
					rc = $fscanf(fd, "%d %s", idx, test_name);
					if (rc != 2)
						abort_run("Bad interrupt record in the data file");
					lines[idx] = 1'b1;
					n_lines = 1;
				end
				else
				begin
					rc = $fscanf(fd, "%d %d %s", idx, idx2, test_name);
					if (rc != 3)
						abort_run("Bad dual interrupt record in the data file");
					lines[idx] = 1'b1;
					lines[idx2] = 1'b1;		// Same cycle
					n_lines = 2;
				end
				have_test = 1'b1;
			end
			else
				abort_run("Unknown record kind in the data file");
		end
		$fclose(fd);
		if (have_test)
			run_interrupts(lines, n_lines);
		if (exp_q.size() == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
		begin
			$display("Expected tx words were left without an interrupt to produce them");
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

endmodule

/* verilog.f */
+incdir+rtl
rtl/lc_pkg.sv
rtl/int_action_table.sv
rtl/lc_reg_file.sv
rtl/lc_cmd_decode.sv
rtl/lc_cmd_execute.sv
rtl/lc_reply_gen.sv
rtl/layer_ctrl.sv
tests/tb_layer_ctrl.sv
